//--- scalar_pkg.sv
package scalar_pkg;

    localparam int data_width    = 32;
    localparam int addr_width    = 12;
    localparam int reg_count     = 16;
    localparam int reg_idx_width = 4;

    // Instruction word markers seen on data_out
    localparam logic [data_width-1:0] halt_marker    = 32'hFFFF_FFFF;
    localparam logic [data_width-1:0] barrier_marker = 32'hAAAA_AAAA;

    typedef enum logic [3:0] {
        op_nop      = 4'd0,
        op_load_imm = 4'd1,
        op_jump     = 4'd2,
        op_branch   = 4'd3,
        op_alu      = 4'd4,
        op_load_pc  = 4'd5,
        op_halt     = 4'd6,
        op_sync     = 4'd7
    } op_t;

    // Codes 5 and 6 are reserved and act as no-ops
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_cmp = 3'd7
    } alu_op_t;

    typedef enum logic [3:0] {
        cond_none   = 4'd0,
        cond_eq     = 4'd1,
        cond_ne     = 4'd2,
        cond_lt     = 4'd3,
        cond_ge     = 4'd4,
        cond_cs     = 4'd5,
        cond_cc     = 4'd6,
        cond_vs     = 4'd7,
        cond_vc     = 4'd8,
        cond_always = 4'd15
    } cond_t;

    typedef enum logic [1:0] {
        stage_fetch     = 2'd0,
        stage_decode    = 2'd1,
        stage_execute   = 2'd2,
        stage_writeback = 2'd3
    } stage_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } flags_t;

    typedef struct packed {
        op_t                      op;
        logic [reg_idx_width-1:0] src;
        logic [reg_idx_width-1:0] dest;
        alu_op_t                  alu_op;
        cond_t                    cond;
        logic [3:0]               sync_sel;
        logic [addr_width-1:0]    addr;
        logic [data_width-1:0]    imm;   // Already sign-extended
        logic                     take_branch;
    } decoded_t;

endpackage

//--- stage_sequencer.sv
`timescale 1ns/1ps

module stage_sequencer (
    input  logic                clock,
    input  logic                reset,
    input  logic                enable,
    input  logic                halt_now,
    output scalar_pkg::stage_t  stage,
    output logic                advance,
    output logic                prog_mem_read
);

    import scalar_pkg::*;

    logic running;

    // Single advance level shared by every unit
    assign advance       = enable & running;
    assign prog_mem_read = enable & running;   // Low while stalled or halted

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage   <= stage_fetch;
            running <= 1'b1;
        end else if (advance) begin
            case (stage)
                stage_fetch:     stage <= stage_decode;
                stage_decode:    stage <= stage_execute;
                stage_execute: begin
                    stage <= stage_writeback;
                    if (halt_now) begin
                        running <= 1'b0;   // Never set again until reset
                    end
                end
                default:         stage <= stage_fetch;
            endcase
        end
    end

    // Stage either holds or steps to its successor
    property p_stage_order;
        @(posedge clock) disable iff (reset)
            1'b1 |=> (stage == $past(stage)) ||
                     (stage == stage_t'($past(stage) + 2'd1));
    endproperty

    a_stage_order: assert property (p_stage_order)
        else $error("stage skipped or moved backwards");

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic [scalar_pkg::data_width-1:0] instruction,
    input  scalar_pkg::flags_t                flags,
    output scalar_pkg::decoded_t              decoded
);

    import scalar_pkg::*;

    logic cond_met;

    // Field split
    always_comb begin
        decoded.op          = op_t'(instruction[31:28]);
        decoded.src         = instruction[27:24];
        decoded.dest        = instruction[23:20];
        decoded.sync_sel    = instruction[19:16];
        decoded.alu_op      = alu_op_t'(instruction[18:16]);   // Overlaps sync_sel
        decoded.cond        = cond_t'(instruction[15:12]);
        decoded.addr        = instruction[addr_width-1:0];
        decoded.imm         = {{(data_width-16){instruction[15]}}, instruction[15:0]};
        decoded.take_branch = (decoded.op == op_branch) && cond_met;
    end

    // Branch condition against current flags
    always_comb begin
        case (cond_t'(instruction[15:12]))
            cond_eq:     cond_met = flags.zero;
            cond_ne:     cond_met = !flags.zero;
            cond_lt:     cond_met = flags.negative;
            cond_ge:     cond_met = !flags.negative;
            cond_cs:     cond_met = flags.carry;
            cond_cc:     cond_met = !flags.carry;
            cond_vs:     cond_met = flags.overflow;
            cond_vc:     cond_met = !flags.overflow;
            cond_always: cond_met = 1'b1;
            default:     cond_met = 1'b0;   // none and undefined codes
        endcase
    end

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 wr_en,
    input  logic [scalar_pkg::reg_idx_width-1:0] wr_idx,
    input  logic [scalar_pkg::data_width-1:0]    wr_data,
    input  logic [scalar_pkg::reg_idx_width-1:0] src_idx,
    input  logic [scalar_pkg::reg_idx_width-1:0] dest_idx,
    output logic [scalar_pkg::data_width-1:0]    src_data,
    output logic [scalar_pkg::data_width-1:0]    dest_data
);

    import scalar_pkg::*;

    logic [data_width-1:0] regs [reg_count];

    // Architectural state, cleared on reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Asynchronous read ports
    assign src_data  = regs[src_idx];
    assign dest_data = regs[dest_idx];

endmodule

//--- alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 execute_en,
    input  scalar_pkg::decoded_t                 decoded,
    input  logic [scalar_pkg::data_width-1:0]    src_data,
    input  logic [scalar_pkg::data_width-1:0]    dest_data,
    output scalar_pkg::flags_t                   flags,
    output logic                                 wr_en,
    output logic [scalar_pkg::reg_idx_width-1:0] wr_idx,
    output logic [scalar_pkg::data_width-1:0]    wr_data
);

    import scalar_pkg::*;

    logic [data_width:0]   sum;   // Extra bit holds carry out
    logic [data_width-1:0] diff;
    logic [data_width-1:0] result;
    logic                  alu_writes;
    logic                  is_cmp;
    flags_t                flags_next;

    always_comb begin
        sum        = {1'b0, dest_data} + {1'b0, src_data};
        diff       = dest_data - src_data;
        result     = '0;
        alu_writes = 1'b0;
        flags_next = flags;   // Reserved codes keep flags
        case (decoded.alu_op)
            alu_add: begin
                result              = sum[data_width-1:0];
                alu_writes          = 1'b1;
                flags_next.carry    = sum[data_width];
                flags_next.overflow = (dest_data[data_width-1] == src_data[data_width-1]) &&
                                      (result[data_width-1] != dest_data[data_width-1]);
            end
            alu_sub, alu_cmp: begin
                result              = diff;
                alu_writes          = (decoded.alu_op == alu_sub);
                flags_next.carry    = (dest_data >= src_data);   // No borrow
                flags_next.overflow = (dest_data[data_width-1] != src_data[data_width-1]) &&
                                      (result[data_width-1] != dest_data[data_width-1]);
            end
            alu_and, alu_or, alu_xor: begin
                if (decoded.alu_op == alu_and) begin
                    result = dest_data & src_data;
                end else if (decoded.alu_op == alu_or) begin
                    result = dest_data | src_data;
                end else begin
                    result = dest_data ^ src_data;
                end
                alu_writes          = 1'b1;
                flags_next.carry    = 1'b0;
                flags_next.overflow = 1'b0;
            end
            default: ;
        endcase
        if (alu_writes || decoded.alu_op == alu_cmp) begin
            flags_next.zero     = (result == '0);
            flags_next.negative = result[data_width-1];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (execute_en && decoded.op == op_alu) begin
            flags <= flags_next;
        end
    end

    // Write port for load_imm or a storing ALU op
    assign wr_en   = execute_en &&
                     ((decoded.op == op_load_imm) || (decoded.op == op_alu && alu_writes));
    assign wr_idx  = decoded.dest;
    assign wr_data = (decoded.op == op_load_imm) ? decoded.imm : result;

    assign is_cmp = (decoded.op == op_alu) && (decoded.alu_op == alu_cmp);

    // Destination register survives a compare
    a_cmp_keeps_dest: assert property (
        @(posedge clock) disable iff (reset)
            (execute_en && is_cmp) |=>
                (decoded.dest != $past(decoded.dest)) || (dest_data == $past(dest_data))
    ) else $error("cmp modified its destination register");

endmodule

//--- pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic                              clock,
    input  logic                              reset,
    input  scalar_pkg::stage_t                stage,
    input  logic                              advance,
    input  scalar_pkg::decoded_t              decoded,
    input  logic [scalar_pkg::data_width-1:0] src_data,
    output logic [scalar_pkg::addr_width-1:0] prog_mem_addr
);

    import scalar_pkg::*;

    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] next_pc;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc            <= '0;
            next_pc       <= '0;
            prog_mem_addr <= '0;
        end else if (advance) begin
            case (stage)
                stage_fetch: prog_mem_addr <= pc;
                stage_execute: begin
                    if (decoded.op == op_jump || decoded.take_branch) begin
                        next_pc <= decoded.addr;   // Jump or taken branch
                    end else if (decoded.op == op_load_pc) begin
                        next_pc <= src_data[addr_width-1:0];
                    end else begin
                        next_pc <= pc + 1'b1;   // Wraps at 12 bits
                    end
                end
                stage_writeback: begin
                    pc            <= next_pc;
                    prog_mem_addr <= next_pc;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- result_port.sv
`timescale 1ns/1ps

module result_port (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              execute_en,
    input  scalar_pkg::decoded_t              decoded,
    input  logic [scalar_pkg::data_width-1:0] src_data,
    output logic [scalar_pkg::data_width-1:0] data_out,
    output logic                              data_valid
);

    import scalar_pkg::*;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_out   <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= 1'b0;   // Pulse lasts one cycle
            if (execute_en) begin
                if (decoded.op == op_halt) begin
                    data_out   <= halt_marker;
                    data_valid <= 1'b1;
                end else if (decoded.op == op_sync && decoded.sync_sel == 4'd0) begin
                    data_out   <= barrier_marker;
                    data_valid <= 1'b1;
                end else if (decoded.op == op_sync && decoded.sync_sel == 4'd1) begin
                    data_out   <= src_data;
                    data_valid <= 1'b1;
                end
            end
        end
    end

    // Execute edges are at least four cycles apart
    a_single_pulse: assert property (
        @(posedge clock) disable iff (reset) data_valid |=> !data_valid
    ) else $error("data_valid held for two cycles");

endmodule

//--- scalar_core.sv
`timescale 1ns/1ps

module scalar_core (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              enable,
    input  logic [scalar_pkg::data_width-1:0] instruction,
    output logic [scalar_pkg::data_width-1:0] data_out,
    output logic                              data_valid,
    output logic [scalar_pkg::addr_width-1:0] prog_mem_addr,
    output logic                              prog_mem_read
);

    import scalar_pkg::*;

    stage_t                   stage;
    logic                     advance;
    logic                     execute_en;
    decoded_t                 decoded;
    flags_t                   flags;
    logic [data_width-1:0]    src_data;
    logic [data_width-1:0]    dest_data;
    logic                     wr_en;
    logic [reg_idx_width-1:0] wr_idx;
    logic [data_width-1:0]    wr_data;

    // All architectural updates happen on this edge
    assign execute_en = advance && (stage == stage_execute);

    stage_sequencer u_seq (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .halt_now      (decoded.op == op_halt),
        .stage         (stage),
        .advance       (advance),
        .prog_mem_read (prog_mem_read)
    );

    instr_decoder u_dec (
        .instruction (instruction),
        .flags       (flags),
        .decoded     (decoded)
    );

    register_file u_regs (
        .clock     (clock),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .src_idx   (decoded.src),
        .dest_idx  (decoded.dest),
        .src_data  (src_data),
        .dest_data (dest_data)
    );

    alu_unit u_alu (
        .clock      (clock),
        .reset      (reset),
        .execute_en (execute_en),
        .decoded    (decoded),
        .src_data   (src_data),
        .dest_data  (dest_data),
        .flags      (flags),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data)
    );

    pc_unit u_pc (
        .clock         (clock),
        .reset         (reset),
        .stage         (stage),
        .advance       (advance),
        .decoded       (decoded),
        .src_data      (src_data),
        .prog_mem_addr (prog_mem_addr)
    );

    result_port u_out (
        .clock      (clock),
        .reset      (reset),
        .execute_en (execute_en),
        .decoded    (decoded),
        .src_data   (src_data),
        .data_out   (data_out),
        .data_valid (data_valid)
    );

endmodule

//--- scalar_ref_model.svh
function automatic logic [31:0] encode_instr(input logic [3:0] op, input logic [3:0] src,
                                             input logic [3:0] dest, input logic [3:0] sel,
                                             input logic [15:0] low);
    return {op, src, dest, sel, low};
endfunction

// Targets only ever move forward, so every program terminates
task automatic forward_target(input int from, output int target);
    target = from + 1 + int'($unsigned($random(seed)) % 32'd24);
    if (target > prog_len - 1) begin
        target = prog_len - 1;   // Last slot holds the halt
    end
endtask

function automatic logic branch_taken(input logic [3:0] cond, input logic zf, input logic nf,
                                      input logic cf, input logic vf);
    case (cond)
        4'd1:    return zf;
        4'd2:    return !zf;
        4'd3:    return nf;
        4'd4:    return !nf;
        4'd5:    return cf;
        4'd6:    return !cf;
        4'd7:    return vf;
        4'd8:    return !vf;
        4'd15:   return 1'b1;
        default: return 1'b0;
    endcase
endfunction

task automatic build_program;
    int         i;
    int         t;
    int         kind;
    logic [3:0] r;
    for (int a = 0; a < 4096; a++) begin
        program_mem[a] = 32'(a);   // Nop carrying its own address
    end
    program_mem[0] = encode_instr(4'd1, 4'd0, 4'd1, 4'd0, 16'hFFFB);   // r1 = -5
    program_mem[1] = encode_instr(4'd7, 4'd1, 4'd0, 4'd1, 16'h0000);   // Output r1
    i = 2;
    while (i < prog_len - 1) begin
        kind = int'($unsigned($random(seed)) % 32'd16);
        r    = 4'($random(seed));
        case (kind)
            0:              program_mem[i] = 32'd0;
            1, 2:           program_mem[i] = encode_instr(4'd1, 4'd0, r, 4'd0, 16'($random(seed)));
            3, 4, 5, 6, 13: program_mem[i] = encode_instr(4'd4, 4'($random(seed)), r,
                                                          {1'b0, 3'($random(seed))}, 16'd0);
            7: begin
                forward_target(i, t);
                program_mem[i] = encode_instr(4'd2, 4'd0, 4'd0, 4'd0, {4'd0, 12'(t)});
            end
            8, 9, 14: begin
                forward_target(i, t);
                program_mem[i] = encode_instr(4'd3, 4'd0, 4'd0, 4'd0, {4'($random(seed)), 12'(t)});
            end
            10, 11, 15: program_mem[i] = encode_instr(4'd7, 4'($random(seed)), 4'd0,
                                                      4'($unsigned($random(seed)) % 32'd3), 16'd0);
            default: begin
                if (i < prog_len - 2) begin
                    forward_target(i + 1, t);
                    program_mem[i]     = encode_instr(4'd1, 4'd0, r, 4'd0, 16'(t));
                    program_mem[i + 1] = encode_instr(4'd5, r, 4'd0, 4'd0, 16'd0);
                    i++;
                end else begin
                    program_mem[i] = 32'd0;
                end
            end
        endcase
        i++;
    end
    program_mem[prog_len - 1] = encode_instr(4'd6, 4'd0, 4'd0, 4'd0, 16'd0);
    // A load_pc only sees its address right after its own load_imm
    for (int j = 0; j < prog_len; j++) begin
        if (program_mem[j][31:28] == 4'd2 || program_mem[j][31:28] == 4'd3) begin
            t = int'(program_mem[j][11:0]);
            while (program_mem[t][31:28] == 4'd5) t++;
            program_mem[j][11:0] = 12'(t);
        end else if (program_mem[j][31:28] == 4'd5) begin
            t = int'(program_mem[j - 1][11:0]);
            while (program_mem[t][31:28] == 4'd5) t++;
            program_mem[j - 1][15:0] = 16'(t);
        end
    end
endtask

task automatic run_model;
    logic [31:0] regs [16];
    logic [31:0] w, s, d, r;
    logic [32:0] wide;
    logic [11:0] pc, next_pc;
    logic        zf, nf, cf, vf, halted;
    int          steps;
    for (int i = 0; i < 16; i++) begin
        regs[i] = 32'd0;
    end
    {zf, nf, cf, vf, halted} = 5'd0;
    pc    = 12'd0;
    steps = 0;
    while (!halted && steps < 4096) begin
        w       = program_mem[pc];
        s       = regs[w[27:24]];
        d       = regs[w[23:20]];
        r       = 32'd0;
        next_pc = pc + 12'd1;
        case (w[31:28])
            4'd1: regs[w[23:20]] = {{16{w[15]}}, w[15:0]};
            4'd2: next_pc = w[11:0];
            4'd3: begin
                if (branch_taken(w[15:12], zf, nf, cf, vf)) begin
                    next_pc = w[11:0];
                end
            end
            4'd4: begin
                case (w[18:16])
                    3'd0: begin
                        wide = {1'b0, d} + {1'b0, s};
                        r    = wide[31:0];
                        cf   = wide[32];
                        vf   = (d[31] == s[31]) && (r[31] != d[31]);
                    end
                    3'd1, 3'd7: begin
                        r  = d - s;
                        cf = (d >= s);
                        vf = (d[31] != s[31]) && (r[31] != d[31]);
                    end
                    3'd2, 3'd3, 3'd4: begin
                        r  = (w[18:16] == 3'd2) ? (d & s) : (w[18:16] == 3'd3) ? (d | s) : (d ^ s);
                        cf = 1'b0;
                        vf = 1'b0;
                    end
                    default: ;
                endcase
                if (w[18:16] != 3'd5 && w[18:16] != 3'd6) begin
                    zf = (r == 32'd0);
                    nf = r[31];
                    if (w[18:16] != 3'd7) regs[w[23:20]] = r;   // cmp keeps dest
                end
            end
            4'd5: next_pc = s[11:0];
            4'd6: begin
                expected_q.push_back(halt_word);
                label_q.push_back("halt marker");
                halted = 1'b1;
            end
            4'd7: begin
                if (w[19:16] == 4'd0) begin
                    expected_q.push_back(barrier_word);
                    label_q.push_back($sformatf("barrier at pc %0d", pc));
                end else if (w[19:16] == 4'd1) begin
                    expected_q.push_back(s);
                    label_q.push_back($sformatf("r%0d output at pc %0d", w[27:24], pc));
                end
            end
            default: ;
        endcase
        pc = next_pc;
        steps++;
    end
    if (!halted) begin
        abort_run("reference model never reached the halt instruction");
    end
endtask

//--- tb_scalar_core.sv
`timescale 1ns/1ps

module tb_scalar_core;

    localparam int          prog_len     = 200;
    localparam logic [31:0] halt_word    = 32'hFFFF_FFFF;
    localparam logic [31:0] barrier_word = 32'hAAAA_AAAA;

    logic        clock;
    logic        reset;
    logic        enable;
    logic [31:0] instruction;
    logic [31:0] data_out;
    logic        data_valid;
    logic [11:0] prog_mem_addr;
    logic        prog_mem_read;

    logic [31:0] program_mem [4096];
    logic [31:0] expected_q [$];
    string       label_q [$];
    integer      seed;
    logic        seen_valid;
    logic [31:0] seen_data;
    logic [31:0] got;

    scalar_core uut (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .instruction   (instruction),
        .data_out      (data_out),
        .data_valid    (data_valid),
        .prog_mem_addr (prog_mem_addr),
        .prog_mem_read (prog_mem_read)
    );

    `include "scalar_ref_model.svh"

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Sample outputs on the falling edge, then drive the next inputs
    task automatic drive_cycle;
        @(negedge clock);
        if (!enable) begin
            check_value("stalled cycle data_valid", 32'd0, 32'(data_valid));
            check_value("stalled cycle prog_mem_read", 32'd0, 32'(prog_mem_read));
        end
        seen_valid  = data_valid;
        seen_data   = data_out;
        enable      = (($random(seed) & 7) != 0);   // Roughly one stall in eight
        instruction = program_mem[prog_mem_addr];
    endtask

    task automatic wait_for_output(output logic [31:0] value);
        int cycles;
        cycles     = 0;
        seen_valid = 1'b0;
        while (!seen_valid && cycles < 2000) begin
            drive_cycle();
            cycles++;
        end
        if (!seen_valid) begin
            abort_run("no output before timeout");
        end else begin
            value = seen_data;
        end
    endtask

    initial begin
        seed        = 65;
        reset       = 1'b1;
        enable      = 1'b0;
        instruction = 32'd0;
        build_program();
        run_model();
        repeat (2) @(negedge clock);
        reset       = 1'b0;
        enable      = 1'b1;
        instruction = program_mem[prog_mem_addr];
        check_value("reset data_valid", 32'd0, 32'(data_valid));
        @(negedge clock);
        check_value("reset prog_mem_read", 32'd1, 32'(prog_mem_read));
        check_value("first fetch address", 32'd0, 32'(prog_mem_addr));
        instruction = program_mem[prog_mem_addr];

        foreach (expected_q[k]) begin
            wait_for_output(got);
            check_value(label_q[k], expected_q[k], got);
        end

        // Halted core stays silent with reads off
        repeat (50) begin
            drive_cycle();
            check_value("pulse after halt", 32'd0, 32'(seen_valid));
            check_value("prog_mem_read after halt", 32'd0, 32'(prog_mem_read));
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
scalar_pkg.sv
stage_sequencer.sv
instr_decoder.sv
register_file.sv
alu_unit.sv
pc_unit.sv
result_port.sv
scalar_core.sv
tb_scalar_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_scalar_core \
    -f filelist.f -o tb_scalar_core

output=$(./obj_dir/tb_scalar_core) || true
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
